/* verilog/usb_pkt_pkg.sv */
// packet-level types, PID codes and endpoint streams shared by the USB device controller
package usb_pkt_pkg;

    typedef logic [3:0] pid_t;                  // PID code without its check nibble
    typedef logic [3:0] endp_t;

    localparam pid_t PID_OUT   = 4'h1;
    localparam pid_t PID_IN    = 4'h9;
    localparam pid_t PID_SETUP = 4'hD;
    localparam pid_t PID_SOF   = 4'h5;
    localparam pid_t PID_DATA0 = 4'h3;
    localparam pid_t PID_DATA1 = 4'hB;
    localparam pid_t PID_ACK   = 4'h2;
    localparam pid_t PID_NAK   = 4'hA;

    // receiver record, fin closes a packet
    typedef struct packed {
        pid_t       pid;
        endp_t      endp;                       // token endpoint field
        logic       byte_en;                    // one strobe per DATA payload byte
        logic [7:0] data;
        logic       fin;                        // end of packet
        logic       okay;                       // packet checks passed, qualifies fin
    } rx_pkt_t;

    // transmitter controls
    typedef struct packed {
        logic       sta;                        // start of handshake or data packet
        pid_t       pid;
        logic [7:0] data;
        logic       fin_n;                      // low at a byte slot ends the packet
    } tx_pkt_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;                      // held for the whole packet
    } in_stream_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;                      // one cycle per byte
    } out_stream_t;

    typedef enum logic [1:0] {OUT_NONE, OUT_SETUP, OUT_EP01} out_sel_t;
    typedef enum logic [1:0] {IN_NONE, IN_EP00, IN_EP81} in_sel_t;

    // ------------------------------------------------
    // load of the IN byte counter
    // ------------------------------------------------
    typedef struct packed {
        logic       load;                       // one-cycle strobe
        in_sel_t    sel;                        // byte source of the packet
        logic [9:0] len;                        // bytes in the next packet
    } tx_load_t;

endpackage

/* verilog/usb_ctrl_pkg.sv */
// control endpoint definitions: SETUP layout, request match codes, descriptors, packet sizes
package usb_ctrl_pkg;

    typedef struct packed {
        logic       dir;                        // 1 = device to host
        logic [1:0] req_type;                   // standard, class, vendor
        logic [4:0] recipient;
    } bm_request_t;

    typedef struct packed {
        logic [15:0] w_length;                  // bytes 7:6
        logic [15:0] w_index;                   // bytes 5:4
        logic [15:0] w_value;                   // bytes 3:2
        logic [7:0]  b_request;                 // byte 1
        bm_request_t bm_request_type;           // byte 0
    } setup_fields_t;

    // same 64 bits seen as wire bytes or as request fields
    typedef union packed {
        logic [7:0][7:0] raw;                   // raw[0] is the first byte received
        setup_fields_t   f;
    } setup_cmd_u;

    localparam int RESP_IDX_W   = 9;
    localparam int EP0_MAX_PKT  = 64;
    localparam int EP81_MAX_PKT = 20;

    localparam int DEVICE_LEN = 18;
    localparam int CONFIG_LEN = 32;
    localparam int STR0_LEN   = 4;

    // ------------------------------------------------
    // descriptors, first byte sent in the top bits
    // ------------------------------------------------
    localparam logic [DEVICE_LEN*8-1:0] DESC_DEVICE = {
        8'h12, 8'h01, 8'h10, 8'h01, 8'h00, 8'h00,   // usb 1.1, class per interface
        8'h00, 8'h40, 8'h34, 8'h12, 8'h78, 8'h56,   // ep0 64 bytes, vendor and product
        8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'h01    // no strings, one configuration
    };

    localparam logic [CONFIG_LEN*8-1:0] DESC_CONFIG = {
        8'h09, 8'h02, 8'h20, 8'h00, 8'h01, 8'h01, 8'h00, 8'h80, 8'h32, // 32 bytes total
        8'h09, 8'h04, 8'h00, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00, 8'h00, // vendor interface
        8'h07, 8'h05, 8'h81, 8'h02, 8'h14, 8'h00, 8'h00,               // bulk in 0x81
        8'h07, 8'h05, 8'h01, 8'h02, 8'h40, 8'h00, 8'h00                // bulk out 0x01
    };

    localparam logic [STR0_LEN*8-1:0] DESC_STR0 = {8'h04, 8'h03, 8'h09, 8'h04}; // us english

    // ------------------------------------------------
    // request codes on {wValue, bRequest, bmRequestType}
    // ------------------------------------------------
    localparam logic [31:0] REQ_MASK_STD  = 32'h0000_FFFF;  // request and type only
    localparam logic [31:0] REQ_MASK_DESC = 32'hFF00_FFFF;  // plus descriptor type
    localparam logic [31:0] REQ_MASK_STR  = 32'hFFFF_FFFF;  // plus string index

    localparam logic [31:0] REQ_GET_CONFIG      = 32'h0000_0880;
    localparam logic [31:0] REQ_GET_DESC_DEVICE = 32'h0100_0680;
    localparam logic [31:0] REQ_GET_DESC_CONFIG = 32'h0200_0680;
    localparam logic [31:0] REQ_GET_DESC_STR0   = 32'h0300_0680;

endpackage

/* verilog/usbfs_txn_ctrl.sv */
// transaction control of the USB device: token decode, data toggles, handshakes and IN loads
`timescale 1ns/1ps

module usbfs_txn_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  usb_pkt_pkg::rx_pkt_t     rp,
    input  usb_ctrl_pkg::setup_cmd_u setup_cmd,
    input  logic                     ep81_valid,
    input  logic                     tx_busy,     // previous IN packet still has bytes
    output logic                     tp_sta,
    output usb_pkt_pkg::pid_t        tp_pid,
    output usb_pkt_pkg::out_sel_t    out_sel,
    output usb_pkt_pkg::tx_load_t    tx_load,
    output logic                     resp_clr,
    output logic                     sot,
    output logic                     sof
);

    usb_pkt_pkg::endp_t endp;                     // endpoint of the last token
    logic               ep00_setup;               // last ep0 token was SETUP
    logic               ep00_data1;
    logic               ep81_data1;
    logic [15:0]        ep00_total;               // answer bytes still owed on ep0
    logic               pkt_end;

    assign pkt_end = rp.fin & rp.okay;

    // received data bytes follow the last token
    always_comb begin
        out_sel = usb_pkt_pkg::OUT_NONE;
        if (endp == 4'd0 && ep00_setup) begin
            out_sel = usb_pkt_pkg::OUT_SETUP;
        end else if (endp == 4'd1) begin
            out_sel = usb_pkt_pkg::OUT_EP01;
        end
    end

    // ------------------------------------------------
    // token and handshake processing
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tp_sta     <= 1'b0;
            tp_pid     <= '0;
            tx_load    <= '0;
            resp_clr   <= 1'b0;
            sot        <= 1'b0;
            sof        <= 1'b0;
            endp       <= '0;
            ep00_setup <= 1'b0;
            ep00_data1 <= 1'b0;
            ep81_data1 <= 1'b0;
            ep00_total <= '0;
        end else begin
            tp_sta       <= 1'b0;                 // strobes
            tx_load.load <= 1'b0;
            resp_clr     <= 1'b0;
            sot          <= 1'b0;
            sof          <= 1'b0;
            if (pkt_end) begin
                if (rp.endp == 4'd0) begin        // ep0 transfer starts at SETUP only
                    sot <= (rp.pid == usb_pkt_pkg::PID_SETUP);
                end else begin
                    sot <= (rp.pid == usb_pkt_pkg::PID_IN) || (rp.pid == usb_pkt_pkg::PID_OUT);
                end
                sof <= (rp.pid == usb_pkt_pkg::PID_SOF);
                case (rp.pid)
                    usb_pkt_pkg::PID_SETUP: begin
                        endp <= rp.endp;
                        if (rp.endp == 4'd0) begin
                            ep00_setup <= 1'b1;
                            ep00_data1 <= 1'b1;   // data stage starts with DATA1
                        end
                    end
                    usb_pkt_pkg::PID_OUT: begin
                        endp <= rp.endp;
                        if (rp.endp == 4'd0) ep00_setup <= 1'b0;
                    end
                    usb_pkt_pkg::PID_IN: begin
                        endp   <= rp.endp;
                        tp_sta <= 1'b1;
                        tp_pid <= usb_pkt_pkg::PID_NAK;   // NAK unless a source is ready
                        if (!tx_busy && rp.endp == 4'd0) begin
                            ep00_setup   <= 1'b0;
                            tp_pid       <= ep00_data1 ? usb_pkt_pkg::PID_DATA1
                                                       : usb_pkt_pkg::PID_DATA0;
                            tx_load.load <= 1'b1;
                            tx_load.sel  <= usb_pkt_pkg::IN_EP00;
                            if (ep00_total >= 16'(usb_ctrl_pkg::EP0_MAX_PKT)) begin
                                tx_load.len <= 10'(usb_ctrl_pkg::EP0_MAX_PKT);  // full packet
                                ep00_total  <= ep00_total - 16'(usb_ctrl_pkg::EP0_MAX_PKT);
                            end else begin
                                tx_load.len <= ep00_total[9:0];   // short or empty tail
                                ep00_total  <= '0;
                            end
                        end else if (!tx_busy && rp.endp == 4'd1 && ep81_valid) begin
                            tp_pid       <= ep81_data1 ? usb_pkt_pkg::PID_DATA1
                                                       : usb_pkt_pkg::PID_DATA0;
                            tx_load.load <= 1'b1;
                            tx_load.sel  <= usb_pkt_pkg::IN_EP81;
                            tx_load.len  <= 10'(usb_ctrl_pkg::EP81_MAX_PKT);
                        end
                    end
                    usb_pkt_pkg::PID_ACK: begin           // host took our data
                        if (endp == 4'd0) ep00_data1 <= ~ep00_data1;
                        if (endp == 4'd1) ep81_data1 <= ~ep81_data1;
                    end
                    usb_pkt_pkg::PID_DATA0, usb_pkt_pkg::PID_DATA1: begin
                        tp_sta <= 1'b1;
                        tp_pid <= usb_pkt_pkg::PID_ACK;
                        if (endp == 4'd0) begin
                            ep00_total <= '0;             // status stage ends the answer
                            if (ep00_setup) begin         // 8-byte command now complete
                                resp_clr <= 1'b1;
                                if (setup_cmd.f.bm_request_type.dir) begin
                                    ep00_total <= setup_cmd.f.w_length;
                                end
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* verilog/usbfs_out_route.sv */
// routes received data bytes into the SETUP command register or out to endpoint 0x01
`timescale 1ns/1ps

module usbfs_out_route (
    input  logic                      clk,
    input  logic                      rstn,
    input  usb_pkt_pkg::rx_pkt_t      rp,
    input  usb_pkt_pkg::out_sel_t     out_sel,
    output usb_ctrl_pkg::setup_cmd_u  setup_cmd,
    output usb_pkt_pkg::out_stream_t  ep01
);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            setup_cmd <= '0;
            ep01      <= '0;
        end else begin
            ep01.valid <= 1'b0;                   // one pulse per byte
            if (rp.byte_en) begin
                case (out_sel)
                    usb_pkt_pkg::OUT_SETUP: begin
                        // new byte enters at the top, first byte ends at raw[0]
                        setup_cmd.raw <= {rp.data, setup_cmd.raw[7:1]};
                    end
                    usb_pkt_pkg::OUT_EP01: begin
                        ep01.data  <= rp.data;
                        ep01.valid <= 1'b1;
                    end
                    default: ;                    // bytes for unknown endpoints dropped
                endcase
            end
        end
    end

endmodule

/* verilog/usbfs_std_resp.sv */
// endpoint 0 answer byte, from the built-in descriptor tables or from the user port
`timescale 1ns/1ps

module usbfs_std_resp (
    input  logic                                 clk,
    input  usb_ctrl_pkg::setup_cmd_u             setup_cmd,
    input  logic [usb_ctrl_pkg::RESP_IDX_W-1:0]  resp_idx,
    input  logic [7:0]                           ep00_resp,    // user answer for resp_idx
    output logic [7:0]                           ep00_byte
);

    logic [31:0] req;                             // {wValue, bRequest, bmRequestType}
    int          idx;

    assign req = setup_cmd.raw[3:0];
    assign idx = int'(resp_idx);

    // registered lookup, one cycle behind index and command
    always_ff @(posedge clk) begin
        if ((req & usb_ctrl_pkg::REQ_MASK_STD) == usb_ctrl_pkg::REQ_GET_CONFIG) begin
            ep00_byte <= (idx == 0) ? 8'h01 : 8'h00;          // configuration 1
        end else if ((req & usb_ctrl_pkg::REQ_MASK_DESC) == usb_ctrl_pkg::REQ_GET_DESC_DEVICE) begin
            ep00_byte <= (idx >= usb_ctrl_pkg::DEVICE_LEN) ? 8'h00 :
                         usb_ctrl_pkg::DESC_DEVICE[(usb_ctrl_pkg::DEVICE_LEN - 1 - idx) * 8 +: 8];
        end else if ((req & usb_ctrl_pkg::REQ_MASK_DESC) == usb_ctrl_pkg::REQ_GET_DESC_CONFIG) begin
            ep00_byte <= (idx >= usb_ctrl_pkg::CONFIG_LEN) ? 8'h00 :
                         usb_ctrl_pkg::DESC_CONFIG[(usb_ctrl_pkg::CONFIG_LEN - 1 - idx) * 8 +: 8];
        end else if ((req & usb_ctrl_pkg::REQ_MASK_STR) == usb_ctrl_pkg::REQ_GET_DESC_STR0) begin
            ep00_byte <= (idx >= usb_ctrl_pkg::STR0_LEN) ? 8'h00 :
                         usb_ctrl_pkg::DESC_STR0[(usb_ctrl_pkg::STR0_LEN - 1 - idx) * 8 +: 8];
        end else begin
            ep00_byte <= ep00_resp;               // everything else answered by the user
        end
    end

endmodule

/* verilog/usbfs_in_tx.sv */
// IN data path: byte counter, source select and endpoint 0 response index
`timescale 1ns/1ps

module usbfs_in_tx (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  usb_pkt_pkg::tx_load_t                tx_load,
    input  logic                                 resp_clr,
    input  logic                                 tp_byte_req,
    input  logic [7:0]                           ep00_byte,
    input  usb_pkt_pkg::in_stream_t              ep81,
    output logic                                 ep81_ready,
    output logic [usb_ctrl_pkg::RESP_IDX_W-1:0]  resp_idx,
    output logic                                 tx_busy,
    output logic [7:0]                           tp_byte,
    output logic                                 tp_fin_n
);

    logic [9:0]           cnt;                    // bytes left in this packet
    usb_pkt_pkg::in_sel_t sel;
    logic                 src_valid;
    logic [7:0]           src_byte;
    logic                 send;

    always_comb begin
        src_valid = 1'b0;
        src_byte  = 8'h00;
        case (sel)
            usb_pkt_pkg::IN_EP00: begin
                src_valid = 1'b1;                 // ep0 answer always available
                src_byte  = ep00_byte;
            end
            usb_pkt_pkg::IN_EP81: begin
                src_valid = ep81.valid;
                src_byte  = ep81.data;
            end
            default: ;
        endcase
    end

    assign tx_busy    = (cnt != 10'd0);
    assign send       = tp_byte_req && tx_busy && src_valid;
    assign ep81_ready = tp_byte_req && tx_busy && (sel == usb_pkt_pkg::IN_EP81);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt      <= '0;
            sel      <= usb_pkt_pkg::IN_NONE;
            resp_idx <= '0;
            tp_fin_n <= 1'b0;
        end else begin
            if (tx_load.load) begin
                cnt <= tx_load.len;
                sel <= tx_load.sel;
            end
            if (resp_clr) resp_idx <= '0;         // new SETUP, answer restarts at 0
            if (tp_byte_req) begin
                tp_fin_n <= send;                 // no byte ends the packet
                cnt      <= send ? cnt - 10'd1 : 10'd0;
                if (send && sel == usb_pkt_pkg::IN_EP00) resp_idx <= resp_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) tp_byte <= src_byte;
    end

endmodule

/* verilog/usbfs_transaction.sv */
// top of the USB full-speed device transaction controller, control and datapath wiring
`timescale 1ns/1ps

module usbfs_transaction (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  usb_pkt_pkg::rx_pkt_t                 rp,
    output usb_pkt_pkg::tx_pkt_t                 tp,
    input  logic                                 tp_byte_req,
    output logic                                 sot,            // start of transfer
    output logic                                 sof,            // start of frame
    output usb_ctrl_pkg::setup_cmd_u             ep00_setup_cmd,
    output logic [usb_ctrl_pkg::RESP_IDX_W-1:0]  ep00_resp_idx,
    input  logic [7:0]                           ep00_resp,
    input  usb_pkt_pkg::in_stream_t              ep81,
    output logic                                 ep81_ready,
    output usb_pkt_pkg::out_stream_t             ep01
);

    logic                  tp_sta;
    usb_pkt_pkg::pid_t     tp_pid;
    logic [7:0]            tp_byte;
    logic                  tp_fin_n;
    usb_pkt_pkg::out_sel_t out_sel;
    usb_pkt_pkg::tx_load_t tx_load;
    logic                  resp_clr;
    logic                  tx_busy;
    logic [7:0]            ep00_byte;

    assign tp = '{sta: tp_sta, pid: tp_pid, data: tp_byte, fin_n: tp_fin_n};

    usbfs_txn_ctrl u_txn_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .rp         (rp),
        .setup_cmd  (ep00_setup_cmd),
        .ep81_valid (ep81.valid),
        .tx_busy    (tx_busy),
        .tp_sta     (tp_sta),
        .tp_pid     (tp_pid),
        .out_sel    (out_sel),
        .tx_load    (tx_load),
        .resp_clr   (resp_clr),
        .sot        (sot),
        .sof        (sof)
    );

    usbfs_out_route u_out_route (
        .clk        (clk),
        .rstn       (rstn),
        .rp         (rp),
        .out_sel    (out_sel),
        .setup_cmd  (ep00_setup_cmd),
        .ep01       (ep01)
    );

    usbfs_std_resp u_std_resp (
        .clk        (clk),
        .setup_cmd  (ep00_setup_cmd),
        .resp_idx   (ep00_resp_idx),
        .ep00_resp  (ep00_resp),
        .ep00_byte  (ep00_byte)
    );

    usbfs_in_tx u_in_tx (
        .clk         (clk),
        .rstn        (rstn),
        .tx_load     (tx_load),
        .resp_clr    (resp_clr),
        .tp_byte_req (tp_byte_req),
        .ep00_byte   (ep00_byte),
        .ep81        (ep81),
        .ep81_ready  (ep81_ready),
        .resp_idx    (ep00_resp_idx),
        .tx_busy     (tx_busy),
        .tp_byte     (tp_byte),
        .tp_fin_n    (tp_fin_n)
    );

endmodule

/* testbench/tb_usbfs_tasks.svh */
// packet drivers, IN packet reader, byte checks and LFSR that the USB transaction testbench top includes
`ifndef TB_USBFS_TASKS_SVH
`define TB_USBFS_TASKS_SVH

// --------------------------------------------------
// random payload and user answer bytes
// --------------------------------------------------
function automatic logic [7:0] lfsr_byte();
    logic [7:0] b;
    logic       fb;
    int         i;
    b = 8'h00;
    for (i = 0; i < 8; i++) begin
        fb         = lfsr_state[16] ^ lfsr_state[13];   // x^17 + x^14 + 1
        lfsr_state = {lfsr_state[15:0], fb};
        b          = {b[6:0], fb};                      // one step per bit
    end
    return b;
endfunction

function automatic logic [7:0] user_byte(input int idx);
    logic [7:0] lo;
    lo = idx[7:0];
    return (lo * 8'd3) ^ 8'h2E ^ {7'd0, idx[8]};        // distinct over one packet
endfunction

// --------------------------------------------------
// checks
// --------------------------------------------------
task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first mismatch");
    end
endtask

task automatic compare_bytes(input string what);
    int i;
    check_equal(got_bytes.size(), exp_bytes.size(), {what, " byte count"});
    for (i = 0; i < exp_bytes.size(); i++) begin
        check_equal(got_bytes[i], exp_bytes[i], $sformatf("%s byte %0d", what, i));
    end
endtask

// descriptor tables hold their first byte in the top bits
task automatic expect_desc(input logic [255:0] desc, input int len);
    logic [255:0] rest;
    int           i;
    exp_bytes.delete();
    rest = desc << (256 - len * 8);                     // first byte moved to bits 255:248
    for (i = 0; i < len; i++) begin
        exp_bytes.push_back(rest[255:248]);
        rest = rest << 8;
    end
endtask

task automatic expect_user(input int first, input int count);
    int i;
    exp_bytes.delete();
    for (i = first; i < first + count; i++) exp_bytes.push_back(user_byte(i));
endtask

// --------------------------------------------------
// packet drivers
// --------------------------------------------------
task automatic send_token(input usb_pkt_pkg::pid_t tok_pid, input usb_pkt_pkg::endp_t tok_endp);
    @(posedge clk);
    rp <= '{pid: tok_pid, endp: tok_endp, byte_en: 1'b0, data: 8'h00, fin: 1'b1, okay: 1'b1};
    @(posedge clk);
    rp <= '0;
    @(negedge clk);                                     // reply cycle of the DUT
endtask

task automatic send_data(input usb_pkt_pkg::pid_t data_pid);
    int i;
    for (i = 0; i < tx_bytes.size(); i++) begin
        @(posedge clk);
        rp <= '{pid: data_pid, endp: 4'd0, byte_en: 1'b1, data: tx_bytes[i], fin: 1'b0,
                okay: 1'b0};
    end
    send_token(data_pid, 4'd0);                         // closing record of the packet
    check_equal(tp.sta, 1'b1, "handshake start after DATA");
    check_equal(tp.pid, usb_pkt_pkg::PID_ACK, "handshake pid after DATA");
endtask

task automatic run_setup(input logic [63:0] cmd);
    int i;
    send_token(usb_pkt_pkg::PID_SETUP, 4'd0);
    check_equal(sot, 1'b1, "sot on SETUP");
    tx_bytes.delete();
    for (i = 0; i < 8; i++) tx_bytes.push_back(cmd[i * 8 +: 8]);    // bmRequestType first
    send_data(usb_pkt_pkg::PID_DATA0);
    for (i = 0; i < 8; i++) begin
        check_equal(ep00_setup_cmd.raw[i], cmd[i * 8 +: 8], $sformatf("SETUP byte %0d", i));
    end
endtask

// IN token followed by byte requests 6 cycles apart until fin_n drops
task automatic read_in_packet(input usb_pkt_pkg::endp_t endp, input usb_pkt_pkg::pid_t exp_pid);
    logic done;
    got_bytes.delete();
    send_token(usb_pkt_pkg::PID_IN, endp);
    check_equal(tp.sta, 1'b1, "IN answer start");
    check_equal(tp.pid, exp_pid, "IN answer pid");
    done = 1'b0;
    while (!done) begin
        repeat (5) @(posedge clk);
        tp_byte_req <= 1'b1;
        @(posedge clk);
        tp_byte_req <= 1'b0;
        @(negedge clk);                                 // byte slot answer
        if (tp.fin_n) begin
            got_bytes.push_back(tp.data);
        end else begin
            done = 1'b1;
        end
    end
endtask

`endif

/* testbench/tb_usbfs_transaction.sv */
// testbench top of the USB transaction controller that runs the directed tests against the DUT
`timescale 1ns/1ps

module tb_usbfs_transaction;

    localparam int CLK_PERIOD = 100;
    localparam int PKT_COUNT  = 32;                     // packets sent by all tests
    localparam int PKT_CYCLES = (usb_ctrl_pkg::EP0_MAX_PKT + 2) * 6 + 10;    // longest IN
    localparam int TIMEOUT_NS = (PKT_COUNT * PKT_CYCLES + 20) * CLK_PERIOD;

    logic                                 clk = 1'b0;
    logic                                 rstn = 1'b0;
    usb_pkt_pkg::rx_pkt_t                 rp = '0;
    usb_pkt_pkg::tx_pkt_t                 tp;
    logic                                 tp_byte_req = 1'b0;
    logic                                 sot;
    logic                                 sof;
    usb_ctrl_pkg::setup_cmd_u             ep00_setup_cmd;
    logic [usb_ctrl_pkg::RESP_IDX_W-1:0]  ep00_resp_idx;
    logic [7:0]                           ep00_resp = 8'h00;
    usb_pkt_pkg::in_stream_t              ep81 = '0;
    logic                                 ep81_ready;
    usb_pkt_pkg::out_stream_t             ep01;
    logic                                 ep81_en = 1'b0;     // source on endpoint 0x81
    logic [16:0]                          lfsr_state = 17'd93578;
    logic [7:0]                           tx_bytes[$];        // payload of next DATA packet
    logic [7:0]                           got_bytes[$];
    logic [7:0]                           exp_bytes[$];
    logic [7:0]                           ep81_sent[$];       // bytes taken with ready
    logic [7:0]                           ep01_got[$];

    always #(CLK_PERIOD / 2) clk = ~clk;

    usbfs_transaction i_usbfs_transaction (
        .clk            (clk),
        .rstn           (rstn),
        .rp             (rp),
        .tp             (tp),
        .tp_byte_req    (tp_byte_req),
        .sot            (sot),
        .sof            (sof),
        .ep00_setup_cmd (ep00_setup_cmd),
        .ep00_resp_idx  (ep00_resp_idx),
        .ep00_resp      (ep00_resp),
        .ep81           (ep81),
        .ep81_ready     (ep81_ready),
        .ep01           (ep01)
    );

    `include "tb_usbfs_tasks.svh"

    always @(posedge clk) ep00_resp <= user_byte(int'(ep00_resp_idx));    // user port

    always @(posedge clk) begin
        ep81.valid <= ep81_en;                          // held across whole packets
        if (ep81_ready) begin
            ep81_sent.push_back(ep81.data);             // taken at this edge
            ep81.data <= lfsr_byte();
        end else if (ep81_en && !ep81.valid) begin
            ep81.data <= lfsr_byte();                   // first byte of the stream
        end
    end

    always @(negedge clk) begin
        if (ep01.valid) ep01_got.push_back(ep01.data);
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT stopped answering before the tests finished");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic reset_and_markers;
        @(negedge clk);
        check_equal({tp.sta, tp.fin_n, sot, sof, ep01.valid, ep81_ready}, 6'b0, "after reset");
        send_token(usb_pkt_pkg::PID_SETUP, 4'd0);
        check_equal({sot, sof}, 2'b10, "markers on SETUP to endpoint 0");
        @(negedge clk);
        check_equal(sot, 1'b0, "sot after one cycle");
        send_token(usb_pkt_pkg::PID_IN, 4'd1);
        check_equal({sot, sof}, 2'b10, "markers on IN to endpoint 1");
        @(negedge clk);
        check_equal({sot, tp.sta}, 2'b00, "sot and sta after one cycle");
        send_token(usb_pkt_pkg::PID_SOF, 4'd0);
        check_equal({sot, sof}, 2'b01, "markers on SOF");
        @(negedge clk);
        check_equal(sof, 1'b0, "sof after one cycle");
        send_token(usb_pkt_pkg::PID_SETUP, 4'd1);
        check_equal(sot, 1'b0, "sot on SETUP to endpoint 1");
    endtask

    task automatic ep0_requests;
        run_setup(64'h0012_0000_0100_0680);             // GetDescriptor device
        expect_desc(256'(usb_ctrl_pkg::DESC_DEVICE), usb_ctrl_pkg::DEVICE_LEN);
        read_in_packet(4'd0, usb_pkt_pkg::PID_DATA1);
        compare_bytes("device descriptor");
        check_equal(ep00_resp_idx, usb_ctrl_pkg::DEVICE_LEN, "response index after descriptor");
        send_token(usb_pkt_pkg::PID_ACK, 4'd0);
        run_setup(64'h0050_0000_0000_01C0);             // vendor request, 80 bytes
        expect_user(0, usb_ctrl_pkg::EP0_MAX_PKT);
        read_in_packet(4'd0, usb_pkt_pkg::PID_DATA1);
        compare_bytes("user answer packet 1");
        send_token(usb_pkt_pkg::PID_ACK, 4'd0);
        expect_user(usb_ctrl_pkg::EP0_MAX_PKT, 80 - usb_ctrl_pkg::EP0_MAX_PKT);
        read_in_packet(4'd0, usb_pkt_pkg::PID_DATA0);
        compare_bytes("user answer packet 2");
        check_equal(ep00_resp_idx, 80, "response index after user answer");
        send_token(usb_pkt_pkg::PID_ACK, 4'd0);
        exp_bytes.delete();
        read_in_packet(4'd0, usb_pkt_pkg::PID_DATA1);
        compare_bytes("user answer tail");
        send_token(usb_pkt_pkg::PID_ACK, 4'd0);
        run_setup(64'h0001_0000_0000_0880);             // GetConfiguration
        exp_bytes.delete();
        exp_bytes.push_back(8'h01);
        read_in_packet(4'd0, usb_pkt_pkg::PID_DATA1);
        compare_bytes("configuration value");
        send_token(usb_pkt_pkg::PID_ACK, 4'd0);
        run_setup(64'h0004_0000_0300_0680);             // GetDescriptor string 0
        expect_desc(256'(usb_ctrl_pkg::DESC_STR0), usb_ctrl_pkg::STR0_LEN);
        read_in_packet(4'd0, usb_pkt_pkg::PID_DATA1);
        compare_bytes("string 0 descriptor");
        send_token(usb_pkt_pkg::PID_ACK, 4'd0);
    endtask

    task automatic bulk_endpoints;
        int mark;
        int i;
        int j;
        @(posedge clk);
        ep81_en <= 1'b1;
        repeat (3) @(posedge clk);
        for (i = 0; i < 2; i++) begin                   // DATA0 first and DATA1 after the ACK
            mark = ep81_sent.size();
            read_in_packet(4'd1, i ? usb_pkt_pkg::PID_DATA1 : usb_pkt_pkg::PID_DATA0);
            check_equal(ep81_sent.size() - mark, usb_ctrl_pkg::EP81_MAX_PKT, "ep81 ready count");
            exp_bytes.delete();
            for (j = mark; j < ep81_sent.size(); j++) exp_bytes.push_back(ep81_sent[j]);
            compare_bytes("ep81 packet");
            send_token(usb_pkt_pkg::PID_ACK, 4'd1);
        end
        @(posedge clk);
        ep81_en <= 1'b0;
        repeat (3) @(posedge clk);
        mark = ep81_sent.size();
        exp_bytes.delete();
        read_in_packet(4'd1, usb_pkt_pkg::PID_NAK);
        compare_bytes("ep81 without valid");
        read_in_packet(4'd3, usb_pkt_pkg::PID_NAK);
        compare_bytes("endpoint 3");
        check_equal(ep81_sent.size(), mark, "ep81 bytes taken during NAK");
        mark = ep01_got.size();
        send_token(usb_pkt_pkg::PID_OUT, 4'd1);
        check_equal({sot, tp.sta}, 2'b10, "OUT to endpoint 1");
        tx_bytes.delete();
        for (i = 0; i < 12; i++) tx_bytes.push_back(lfsr_byte());
        exp_bytes = tx_bytes;
        send_data(usb_pkt_pkg::PID_DATA0);
        repeat (2) @(negedge clk);
        got_bytes.delete();
        for (j = mark; j < ep01_got.size(); j++) got_bytes.push_back(ep01_got[j]);
        compare_bytes("ep01 stream");
    endtask

    initial begin
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        reset_and_markers();
        ep0_requests();
        bulk_endpoints();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sim.f */
+incdir+testbench
verilog/usb_pkt_pkg.sv
verilog/usb_ctrl_pkg.sv
verilog/usbfs_txn_ctrl.sv
verilog/usbfs_out_route.sv
verilog/usbfs_std_resp.sv
verilog/usbfs_in_tx.sv
verilog/usbfs_transaction.sv
testbench/tb_usbfs_transaction.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_usbfs_transaction \
    -o tb_usbfs_transaction > sim.log 2>&1 \
    && ./obj_dir/tb_usbfs_transaction >> sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
